//--- hdl/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;

    // opcode field values, bits 31..27
    typedef enum logic [4:0] {
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opAndi = 5'b01101,
        opOri  = 5'b01110,
        opOut  = 5'b10111
    } opcodeT;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpT;

    // top bit of each instruction field
    localparam int opcodeMsb = 31;
    localparam int raMsb     = 26;
    localparam int rbMsb     = 22;
    localparam int rcMsb     = 18;
    localparam int constMsb  = 18; // 19 bit constant shares bits with Rc

    localparam int regCount = 16;

endpackage

//--- hdl/datapathCtrlIf.sv
`timescale 1ns/1ps

interface datapathCtrlIf;

    logic gra;
    logic grb;
    logic grc;
    logic rIn;
    logic rOut;
    logic baOut;
    logic cOut;
    logic yIn;
    logic zIn;
    logic zOut;
    cpuPkg::aluOpT aluOp;
    logic outPortIn;

    modport control (
        output gra, grb, grc, rIn, rOut, baOut,
        output cOut, yIn, zIn, zOut, aluOp, outPortIn
    );

    modport select (input gra, grb, grc, rIn, rOut, baOut);

    modport alu (input cOut, yIn, zIn, zOut, aluOp);

    modport regs (input baOut);

endinterface

//--- hdl/selectEncode.sv
`timescale 1ns/1ps

module selectEncode (
    datapathCtrlIf.select ctrl,
    input  cpuPkg::wordT  ir,
    output logic [15:0]   regEnables,
    output logic [15:0]   regOuts,
    output cpuPkg::wordT  cSignExt
);

    logic [3:0]  regSel;
    logic [15:0] oneHot;

    // several fields may be selected at once, they are ORed like the bus logic
    always_comb
    begin
        regSel = (ir[cpuPkg::raMsb -: 4] & {4{ctrl.gra}})
               | (ir[cpuPkg::rbMsb -: 4] & {4{ctrl.grb}})
               | (ir[cpuPkg::rcMsb -: 4] & {4{ctrl.grc}});
    end

    always_comb
    begin
        oneHot = '0;
        oneHot[regSel] = 1'b1;
    end

    assign regEnables = ctrl.rIn ? oneHot : 16'h0000;
    assign regOuts    = (ctrl.rOut | ctrl.baOut) ? oneHot : 16'h0000; // BA_out also drives the read

    // C is bits 18..0, extended from its top bit
    assign cSignExt = {{(31 - cpuPkg::constMsb){ir[cpuPkg::constMsb]}},
                       ir[cpuPkg::constMsb:0]};

endmodule

//--- hdl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                          clock,
    input  logic                          arstN,
    datapathCtrlIf.regs                   ctrl,
    input  logic [cpuPkg::regCount-1:0]   regEnables,
    input  logic [cpuPkg::regCount-1:0]   regOuts,
    input  cpuPkg::wordT                  bus,
    output cpuPkg::wordT                  regData
);

    cpuPkg::wordT regs [cpuPkg::regCount];

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < cpuPkg::regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < cpuPkg::regCount; i++)
            begin
                if (regEnables[i])
                begin
                    regs[i] <= bus;
                end
            end
        end
    end

    // wired-OR of every enabled register
    always_comb
    begin
        regData = '0;
        for (int i = 0; i < cpuPkg::regCount; i++)
        begin
            if (regOuts[i] && !(i == 0 && ctrl.baOut)) // R0 reads zero under BA_out
            begin
                regData = regData | regs[i];
            end
        end
    end

endmodule

//--- hdl/aluDatapath.sv
`timescale 1ns/1ps

module aluDatapath (
    input  logic          clock,
    input  logic          arstN,
    datapathCtrlIf.alu    ctrl,
    input  cpuPkg::wordT  regData,
    input  cpuPkg::wordT  cSignExt,
    output cpuPkg::wordT  bus
);

    cpuPkg::wordT yReg;
    cpuPkg::wordT zReg;
    cpuPkg::wordT aluResult;

    // Z has priority, then the constant, else whatever the registers drive
    always_comb
    begin
        if (ctrl.zOut)
        begin
            bus = zReg;
        end
        else if (ctrl.cOut)
        begin
            bus = cSignExt;
        end
        else
        begin
            bus = regData;
        end
    end

    always_comb
    begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd: aluResult = yReg + bus;
            cpuPkg::aluSub: aluResult = yReg - bus; // wraps at 32 bits
            cpuPkg::aluAnd: aluResult = yReg & bus;
            cpuPkg::aluOr:  aluResult = yReg | bus;
            default:        aluResult = '0;
        endcase
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            yReg <= '0;
        end
        else if (ctrl.yIn)
        begin
            yReg <= bus;
        end
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            zReg <= '0;
        end
        else if (ctrl.zIn)
        begin
            zReg <= aluResult;
        end
    end

endmodule

//--- hdl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic           clock,
    input  logic           arstN,
    input  cpuPkg::wordT   instr,
    input  logic           instrValid,
    input  cpuPkg::wordT   bus,
    datapathCtrlIf.control ctrl,
    output cpuPkg::wordT   ir,
    output logic           busy,
    output logic           done,
    output cpuPkg::wordT   outPort,
    output logic           outValid
);

    logic [1:0]     step;   // 0 is idle
    cpuPkg::opcodeT opcode;
    cpuPkg::aluOpT  aluSel;
    logic           isRType;
    logic           isImm;
    logic           multiStep;
    logic           accept;
    cpuPkg::wordT   outReg;

    assign opcode = cpuPkg::opcodeT'(ir[cpuPkg::opcodeMsb -: 5]);

    always_comb
    begin
        isRType = 1'b0;
        isImm   = 1'b0;
        aluSel  = cpuPkg::aluAdd;
        case (opcode)
            cpuPkg::opAdd:  isRType = 1'b1;
            cpuPkg::opSub:
            begin
                isRType = 1'b1;
                aluSel  = cpuPkg::aluSub;
            end
            cpuPkg::opAnd:
            begin
                isRType = 1'b1;
                aluSel  = cpuPkg::aluAnd;
            end
            cpuPkg::opOr:
            begin
                isRType = 1'b1;
                aluSel  = cpuPkg::aluOr;
            end
            cpuPkg::opAddi: isImm = 1'b1;
            cpuPkg::opAndi:
            begin
                isImm  = 1'b1;
                aluSel = cpuPkg::aluAnd;
            end
            cpuPkg::opOri:
            begin
                isImm  = 1'b1;
                aluSel = cpuPkg::aluOr;
            end
            default: ; // out and undefined opcodes finish in one step
        endcase
    end

    assign multiStep = isRType | isImm;
    assign busy      = (step != 2'd0);
    assign accept    = instrValid & ~busy;
    assign done      = (step == 2'd3) | ((step == 2'd1) & ~multiStep);

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            step <= 2'd0;
            ir   <= '0;
        end
        else if (accept)
        begin
            ir   <= instr;
            step <= 2'd1;
        end
        else if (done)
        begin
            step <= 2'd0;
        end
        else if (busy)
        begin
            step <= step + 2'd1;
        end
    end

    // strobe pattern per step
    always_comb
    begin
        ctrl.gra       = 1'b0;
        ctrl.grb       = 1'b0;
        ctrl.grc       = 1'b0;
        ctrl.rIn       = 1'b0;
        ctrl.rOut      = 1'b0;
        ctrl.baOut     = 1'b0;
        ctrl.cOut      = 1'b0;
        ctrl.yIn       = 1'b0;
        ctrl.zIn       = 1'b0;
        ctrl.zOut      = 1'b0;
        ctrl.aluOp     = cpuPkg::aluAdd;
        ctrl.outPortIn = 1'b0;
        case (step)
            2'd1:
            begin
                if (multiStep)
                begin
                    ctrl.grb   = 1'b1;          // Rb into Y
                    ctrl.rOut  = isRType;
                    ctrl.baOut = isImm;         // immediates read R0 as zero
                    ctrl.yIn   = 1'b1;
                end
                else if (opcode == cpuPkg::opOut)
                begin
                    ctrl.gra       = 1'b1;
                    ctrl.rOut      = 1'b1;
                    ctrl.outPortIn = 1'b1;
                end
            end
            2'd2:
            begin
                ctrl.grc   = isRType;
                ctrl.rOut  = isRType;
                ctrl.cOut  = isImm;
                ctrl.zIn   = 1'b1;
                ctrl.aluOp = aluSel;
            end
            2'd3:
            begin
                ctrl.zOut = 1'b1;               // Z back into Ra
                ctrl.gra  = 1'b1;
                ctrl.rIn  = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clock or negedge arstN)
    begin
        if (!arstN)
        begin
            outReg <= '0;
        end
        else if (ctrl.outPortIn)
        begin
            outReg <= bus;
        end
    end

    // bus passes straight through on the out step so the value is there with done
    assign outPort  = ctrl.outPortIn ? bus : outReg;
    assign outValid = ctrl.outPortIn;

endmodule

//--- hdl/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic          clock,
    input  logic          arstN,
    input  cpuPkg::wordT  instr,
    input  logic          instrValid,
    output logic          busy,
    output logic          done,
    output cpuPkg::wordT  outPort,
    output logic          outValid
);

    cpuPkg::wordT ir;
    cpuPkg::wordT cSignExt;
    cpuPkg::wordT regData;
    cpuPkg::wordT bus;
    logic [15:0]  regEnables;
    logic [15:0]  regOuts;

    datapathCtrlIf ctrlBus ();

    controlUnit control (
        .clock      (clock),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .bus        (bus),
        .ctrl       (ctrlBus),
        .ir         (ir),
        .busy       (busy),
        .done       (done),
        .outPort    (outPort),
        .outValid   (outValid)
    );

    selectEncode select (
        .ctrl       (ctrlBus),
        .ir         (ir),
        .regEnables (regEnables),
        .regOuts    (regOuts),
        .cSignExt   (cSignExt)
    );

    regFile regs (
        .clock      (clock),
        .arstN      (arstN),
        .ctrl       (ctrlBus),
        .regEnables (regEnables),
        .regOuts    (regOuts),
        .bus        (bus),
        .regData    (regData)
    );

    aluDatapath alu (
        .clock      (clock),
        .arstN      (arstN),
        .ctrl       (ctrlBus),
        .regData    (regData),
        .cSignExt   (cSignExt),
        .bus        (bus)
    );

endmodule

//--- testbench/cpuCore_assertions.sv
`timescale 1ns/1ps

module cpuCoreAssertions (
    input logic         clock,
    input logic         arstN,
    input logic         instrValid,
    input logic         busy,
    input logic         done,
    input logic         outValid,
    input cpuPkg::wordT ir,
    input logic         gra,
    input logic         grb,
    input logic         grc,
    input logic         rIn,
    input logic         rOut,
    input logic         baOut,
    input logic         cOut,
    input logic         yIn,
    input logic         zIn,
    input logic         zOut,
    input logic         outPortIn
);

    logic anyStrobe;
    int   failCount = 0;

    assign anyStrobe = gra | grb | grc | rIn | rOut | baOut | cOut | yIn | zIn | zOut | outPortIn;

    doneSingle: assert property (@(posedge clock) disable iff (!arstN) done |=> !done)
        else
        begin
            failCount++;
            $error("done high for two cycles in a row");
        end

    outValidSingle: assert property (@(posedge clock) disable iff (!arstN) outValid |=> !outValid)
        else
        begin
            failCount++;
            $error("outValid high for two cycles in a row");
        end

    // a held instruction register means the offer was dropped
    busyDropsInstr: assert property (@(posedge clock) disable iff (!arstN)
        busy && instrValid |=> $stable(ir))
        else
        begin
            failCount++;
            $error("instruction accepted while busy");
        end

    yzExclusive: assert property (@(posedge clock) disable iff (!arstN) !(yIn && zIn))
        else
        begin
            failCount++;
            $error("yIn and zIn high together");
        end

    quietInReset: assert property (@(posedge clock) !arstN |-> !anyStrobe)
        else
        begin
            failCount++;
            $error("control strobe high during reset");
        end

endmodule

//--- testbench/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

    localparam int timeoutCycles = 20;

    logic         clock;
    logic         arstN;
    cpuPkg::wordT instr;
    logic         instrValid;
    logic         busy;
    logic         done;
    cpuPkg::wordT outPort;
    logic         outValid;

    cpuPkg::wordT model [cpuPkg::regCount];
    integer       seed = 32'ha5ef;
    int           errorCount = 0;
    int           testCount = 0;
    int           failedTests = 0;
    int           testErrors = 0;   // error count when the current test began

    // what the last instruction did
    int           latency;
    int           outPulses;
    logic         outAtDone;
    cpuPkg::wordT lastOut;

    cpuCore uut (
        .clock      (clock),
        .arstN      (arstN),
        .instr      (instr),
        .instrValid (instrValid),
        .busy       (busy),
        .done       (done),
        .outPort    (outPort),
        .outValid   (outValid)
    );

    bind controlUnit cpuCoreAssertions ctrlChecks (
        .clock(clock), .arstN(arstN), .instrValid(instrValid), .busy(busy),
        .done(done), .outValid(outValid), .ir(ir),
        .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc), .rIn(ctrl.rIn),
        .rOut(ctrl.rOut), .baOut(ctrl.baOut), .cOut(ctrl.cOut), .yIn(ctrl.yIn),
        .zIn(ctrl.zIn), .zOut(ctrl.zOut), .outPortIn(ctrl.outPortIn)
    );

    always #10 clock = ~clock;

    // Rc sits in the top four bits of low for register ops
    function automatic cpuPkg::wordT encode(input logic [4:0] op, input logic [3:0] ra,
                                            input logic [3:0] rb, input logic [18:0] low);
        cpuPkg::wordT w;
        w = '0;
        w[cpuPkg::opcodeMsb -: 5] = op;
        w[cpuPkg::raMsb -: 4]     = ra;
        w[cpuPkg::rbMsb -: 4]     = rb;
        w[cpuPkg::constMsb:0]     = low;
        return w;
    endfunction

    function automatic cpuPkg::wordT signExtend(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    task automatic reportMismatch(input string name, input cpuPkg::wordT got,
                                  input cpuPkg::wordT exp);
        errorCount++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic waitIdle();
        int waitCycles;
        waitCycles = 0;
        while (busy && waitCycles < timeoutCycles)
        begin
            @(negedge clock);
            waitCycles++;
        end
        if (busy)
            reportFailure("busy stayed high, the core never went idle");
    endtask

    // latency counts falling edges from acceptance to done, inclusive
    task automatic issueInstr(input cpuPkg::wordT word);
        waitIdle();
        instr      = word;
        instrValid = 1'b1;
        @(negedge clock);
        instrValid = 1'b0;
        latency    = 1;
        outPulses  = 0;
        while (!done && latency < timeoutCycles)
        begin
            if (outValid)
                outPulses++;
            @(negedge clock);
            latency++;
        end
        if (outValid)
            outPulses++;
        outAtDone = outValid;
        lastOut   = outPort;
        if (!done)
            reportFailure($sformatf("done never came for instruction %h", word));
    endtask

    task automatic execute(input logic [4:0] op, input logic [3:0] ra, input logic [3:0] rb,
                           input logic [18:0] low);
        cpuPkg::wordT bVal;
        cpuPkg::wordT cVal;
        bVal = model[rb];
        cVal = model[low[18:15]];
        if (op == cpuPkg::opAddi || op == cpuPkg::opAndi || op == cpuPkg::opOri)
        begin
            bVal = (rb == 4'd0) ? 32'h0 : model[rb];  // R0 is zero for immediates
            cVal = signExtend(low);
        end
        case (op)
            cpuPkg::opAdd, cpuPkg::opAddi: model[ra] = bVal + cVal;
            cpuPkg::opSub:                 model[ra] = bVal - cVal;
            cpuPkg::opAnd, cpuPkg::opAndi: model[ra] = bVal & cVal;
            default:                       model[ra] = bVal | cVal;
        endcase
        issueInstr(encode(op, ra, rb, low));
        if (latency != 3)
            reportFailure($sformatf("opcode %b done after %0d cycles, not 3", op, latency));
    endtask

    task automatic expectReg(input logic [3:0] idx);
        issueInstr(encode(cpuPkg::opOut, idx, 4'd0, 19'h0));
        if (lastOut !== model[idx])
            reportMismatch($sformatf("outPort (R%0d)", idx), lastOut, model[idx]);
        if (latency != 1 || outPulses != 1 || !outAtDone)
            reportFailure($sformatf("out R%0d: done after %0d cycles, %0d outValid pulses",
                                    idx, latency, outPulses));
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == testErrors)
            $display("test %-20s ok", name);
        else
        begin
            failedTests++;
            $display("test %-20s %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    task automatic resetTest();
        if ({busy, done, outValid} !== 3'b000)
            reportMismatch("{busy,done,outValid}", 32'({busy, done, outValid}), 32'h0);
        if (outPort !== 32'h0)
            reportMismatch("outPort", outPort, 32'h0);
        for (int i = 0; i < cpuPkg::regCount; i++)
            expectReg(4'(i));
        endTest("reset state");
    endtask

    task automatic constantTest();
        logic [31:0] r;
        for (int i = 1; i <= 6; i++)
        begin
            r = $random(seed);
            execute(cpuPkg::opAddi, 4'(i), 4'd0, {i[0], r[17:0]});  // odd i negative
        end
        execute(cpuPkg::opAddi, 4'd7, 4'd0, 19'h40000);
        execute(cpuPkg::opAddi, 4'd8, 4'd0, 19'h3ffff);
        execute(cpuPkg::opAddi, 4'd0, 4'd0, 19'h00abc);  // R0 now holds a value
        execute(cpuPkg::opAddi, 4'd9, 4'd0, 19'h00011);  // but still reads zero here
        for (int i = 0; i <= 9; i++)
            expectReg(4'(i));
        endTest("constant load");
    endtask

    task automatic arithmeticTest();
        logic [31:0] r;
        logic [4:0]  op;
        logic [3:0]  ra;
        for (int i = 1; i < cpuPkg::regCount; i++)
        begin
            r = $random(seed);
            execute(cpuPkg::opAddi, 4'(i), 4'd0, r[18:0]);
        end
        for (int i = 0; i < 16; i++)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    op = cpuPkg::opAdd;
                2'd1:    op = cpuPkg::opSub;
                2'd2:    op = cpuPkg::opAnd;
                default: op = cpuPkg::opOr;
            endcase
            ra = (r[7:4] == 4'd0) ? 4'd1 : r[7:4];
            execute(op, ra, r[11:8], {r[15:12], 15'h0});
            expectReg(ra);
        end
        execute(cpuPkg::opSub, 4'd3, 4'd3, {4'd7, 15'h0});  // Ra is Rb
        execute(cpuPkg::opOr, 4'd4, 4'd6, {4'd4, 15'h0});   // Ra is Rc
        for (int i = 0; i < 14; i++)
            execute(cpuPkg::opAdd, 4'd9, 4'd9, {4'd9, 15'h0});  // doubling past 32 bits
        for (int i = 1; i < cpuPkg::regCount; i++)
            expectReg(4'(i));
        endTest("register arithmetic");
    endtask

    task automatic immediateTest();
        logic [31:0] r;
        logic [3:0]  ra;
        for (int i = 0; i < 12; i++)
        begin
            r  = $random(seed);
            ra = (r[31:28] == 4'd0) ? 4'd2 : r[31:28];
            execute(i[1] ? cpuPkg::opAndi : cpuPkg::opOri, ra, r[23:20], {i[0], r[17:0]});
            expectReg(ra);
        end
        endTest("immediate logic");
    endtask

    task automatic timingTest();
        execute(cpuPkg::opAddi, 4'd12, 4'd0, 19'h00123);
        if (busy !== 1'b1)
            reportMismatch("busy", 32'(busy), 32'h1);
        @(negedge clock);
        if (busy !== 1'b0)
            reportMismatch("busy", 32'(busy), 32'h0);
        expectReg(4'd12);
        model[10] = model[1] + model[2];
        waitIdle();
        instr      = encode(cpuPkg::opAdd, 4'd10, 4'd1, {4'd2, 15'h0});
        instrValid = 1'b1;
        @(negedge clock);
        if (busy !== 1'b1)
            reportMismatch("busy", 32'(busy), 32'h1);
        instr = encode(cpuPkg::opAddi, 4'd12, 4'd0, 19'h00777);  // offered while busy
        @(negedge clock);
        instrValid = 1'b0;
        waitIdle();
        expectReg(4'd10);
        expectReg(4'd12);
        endTest("timing");
    endtask

    task automatic undefinedTest();
        expectReg(4'd5);
        for (int k = 0; k < 2; k++)
        begin
            issueInstr(encode(k[0] ? 5'b00000 : 5'b11111, 4'd5, 4'd5, 19'h7ffff));
            if (latency != 1 || outPulses != 0)
                reportFailure($sformatf("undefined opcode: done after %0d cycles, %0d outValid",
                                        latency, outPulses));
            if (lastOut !== model[5])
                reportMismatch("outPort", lastOut, model[5]);
        end
        for (int i = 1; i < cpuPkg::regCount; i++)
            expectReg(4'(i));
        endTest("undefined opcode");
    endtask

    initial
    begin
        clock      = 1'b0;
        arstN      = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        for (int i = 0; i < cpuPkg::regCount; i++)
            model[i] = '0;
        repeat (16) @(negedge clock);
        arstN = 1'b1;
        resetTest();
        constantTest();
        arithmeticTest();
        immediateTest();
        timingTest();
        undefinedTest();
        errorCount += uut.control.ctrlChecks.failCount;  // bound assertion failures
        $display("tests run %0d, tests failed %0d, errors %0d", testCount, failedTests,
                 errorCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim.f
hdl/cpuPkg.sv
hdl/datapathCtrlIf.sv
hdl/selectEncode.sv
hdl/regFile.sv
hdl/aluDatapath.sv
hdl/controlUnit.sv
hdl/cpuCore.sv
testbench/cpuCore_assertions.sv
testbench/cpuCoreTb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpuCoreTb
FILELIST = sim.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
